// ==== hdl/pcm_pkg.sv ====
/*
  Shared definitions for the two-channel PCM sample player.
  Holds the register map constants, the widths of the ROM address and
  the prescaler, and the packed structs handed from the register stage
  to the channels and to the mixer. Other files refer to these by
  scoped names.
*/
package pcm_pkg;

    // control register file size
    localparam int num_regs = 14;

    // sample ROM address width, 128 KiB per channel
    localparam int rom_aw = 17;

    // prescaler counter width
    localparam int pre_w = 12;

    // offset-binary zero point of the 7-bit sample code
    localparam int sample_offset = 64;

    // any write to these starts the channel
    localparam int reg_play_a = 5;
    localparam int reg_play_b = 11;

    // register map for channel A
    // channel B uses the same layout six registers higher
    localparam int reg_pre_lo  = 0;
    localparam int reg_pre_hi  = 1;
    localparam int reg_addr_lo = 2;
    localparam int reg_addr_md = 3;
    localparam int reg_addr_hi = 4;
    localparam int reg_chan_b  = 6;

    // shared registers
    localparam int reg_gain = 12;
    localparam int reg_loop = 13;

    // one channel's settings
    typedef struct packed {
        // first byte of the sample
        logic [rom_aw-1:0] start;
        // prescaler reload value
        logic [pre_w-1:0]  pre;
        // prescaler length select
        logic [1:0]        pre_sel;
        // restart at start on an end-marked byte
        logic              loop;
        // single-cycle start pulse
        logic              play;
    } chan_ctrl_t;

    // mixer gains, unsigned, 15 is just under unity
    typedef struct packed {
        logic [3:0] gain_a;
        logic [3:0] gain_b;
    } mix_ctrl_t;

endpackage

// ==== hdl/pcm_regs.sv ====
/*
  Register stage of the PCM player.
  The host writes one byte per cycle of the wr strobe, with no separate
  write enable. The fourteen registers are unpacked into the per-channel
  control structs and the mixer gains. The stage also makes the play
  pulses and the E and Q clock enables, each at a quarter of the cen rate.
*/
`timescale 1ns/1ns

module pcm_regs (
    input  logic                clk,
    input  logic                rst,
    input  logic                cen,
    input  logic                wr,
    input  logic [3:0]          reg_addr,
    input  logic [7:0]          data,
    output logic                cen_e,
    output logic                cen_q,
    output pcm_pkg::chan_ctrl_t ctrl_a,
    output pcm_pkg::chan_ctrl_t ctrl_b,
    output pcm_pkg::mix_ctrl_t  mix
);

    // register array, not every bit is used
    logic [7:0] regs [pcm_pkg::num_regs];
    logic       play_a;
    logic       play_b;
    // E/Q phase counter
    logic [1:0] phase;

    // gather one channel's fields from its five setting registers
    function automatic pcm_pkg::chan_ctrl_t chan_fields(
        input logic [7:0] pre_lo,
        input logic [7:0] pre_hi,
        input logic [7:0] addr_lo,
        input logic [7:0] addr_md,
        input logic [7:0] addr_hi,
        input logic       loop,
        input logic       play
    );
        pcm_pkg::chan_ctrl_t c;
        c.pre     = {pre_hi[3:0], pre_lo};
        c.pre_sel = pre_hi[5:4];
        c.start   = {addr_hi[0], addr_md, addr_lo};
        c.loop    = loop;
        c.play    = play;
        return c;
    endfunction

    // byte writes, addresses 14 and 15 fall through
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < pcm_pkg::num_regs; i++) begin
                regs[i] <= '0;
            end
            play_a <= 1'b0;
            play_b <= 1'b0;
        end else begin
            if (wr && (reg_addr < 4'(pcm_pkg::num_regs))) begin
                regs[reg_addr] <= data;
            end
            // the data byte itself does not matter
            play_a <= wr && (reg_addr == 4'(pcm_pkg::reg_play_a));
            play_b <= wr && (reg_addr == 4'(pcm_pkg::reg_play_b));
        end
    end

    // E and Q enables in opposite phases, one cen pulse each out of four
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= 2'd0;
            cen_e <= 1'b0;
            cen_q <= 1'b0;
        end else begin
            if (cen) begin
                phase <= phase + 2'd1;
            end
            cen_q <= cen && (phase == 2'd1);
            cen_e <= cen && (phase == 2'd3);
        end
    end

    // channel A fields
    assign ctrl_a = chan_fields(regs[pcm_pkg::reg_pre_lo], regs[pcm_pkg::reg_pre_hi],
                                regs[pcm_pkg::reg_addr_lo], regs[pcm_pkg::reg_addr_md],
                                regs[pcm_pkg::reg_addr_hi], regs[pcm_pkg::reg_loop][0],
                                play_a);

    // channel B, same layout shifted by six registers
    assign ctrl_b = chan_fields(regs[pcm_pkg::reg_chan_b + pcm_pkg::reg_pre_lo],
                                regs[pcm_pkg::reg_chan_b + pcm_pkg::reg_pre_hi],
                                regs[pcm_pkg::reg_chan_b + pcm_pkg::reg_addr_lo],
                                regs[pcm_pkg::reg_chan_b + pcm_pkg::reg_addr_md],
                                regs[pcm_pkg::reg_chan_b + pcm_pkg::reg_addr_hi],
                                regs[pcm_pkg::reg_loop][1], play_b);

    // gain A in the high nibble
    assign mix.gain_a = regs[pcm_pkg::reg_gain][7:4];
    assign mix.gain_b = regs[pcm_pkg::reg_gain][3:0];

endmodule

// ==== hdl/pcm_channel.sv ====
/*
  One PCM playback channel.
  A reloadable prescaler running on cen_q sets the sample rate. At each
  overflow the channel takes a byte from its ROM port, turns the 7-bit
  offset-binary code into a signed sample and steps the address. A byte
  with bit 7 set ends the sample, and the channel then loops or stops.
  A missing rom_ok holds everything until the next overflow.
*/
`timescale 1ns/1ns

module pcm_channel (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cen_q,
    input  pcm_pkg::chan_ctrl_t               ctrl,
    output logic [pcm_pkg::rom_aw-1:0]        rom_addr,
    output logic                              rom_cs,
    input  logic                              rom_ok,
    input  logic [7:0]                        rom_dout,
    output logic signed [6:0]                 snd
);

    // prescaler count
    logic [pcm_pkg::pre_w-1:0] cnt;
    // selected bits all ones
    logic                      over;
    // overflow tick, one clock wide
    logic                      tick;
    logic                      busy;
    // decoded sample of the current byte
    logic signed [6:0]         code;

    // counter length from pre_sel
    // bit 0 wins over bit 1
    always_comb begin
        if (ctrl.pre_sel[0]) begin
            over = &cnt[7:0];
        end else if (ctrl.pre_sel[1]) begin
            over = &cnt[pcm_pkg::pre_w-1:8];
        end else begin
            over = &cnt;
        end
    end

    assign tick = cen_q && over;

    // offset binary to two's complement
    assign code = $signed(rom_dout[6:0] - 7'(pcm_pkg::sample_offset));

    // ROM select follows the busy flag directly
    assign rom_cs = busy;

    // prescaler, counts up on cen_q and reloads on overflow
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (cen_q) begin
            if (over) begin
                cnt <= ctrl.pre;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // address walker and sample register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy     <= 1'b0;
            rom_addr <= '0;
            snd      <= '0;
        end else begin
            if (tick) begin
                if (!busy) begin
                    // idle channel is silent
                    snd <= '0;
                end else if (rom_ok) begin
                    snd      <= code;
                    rom_addr <= rom_addr + 1'b1;
                    // end marker
                    if (rom_dout[7]) begin
                        if (ctrl.loop) begin
                            rom_addr <= ctrl.start;
                        end else begin
                            busy <= 1'b0;
                        end
                    end
                end
                // busy without rom_ok holds snd and rom_addr
                // so the same byte is fetched at the next tick
            end
            // a start overrides whatever the tick did
            if (ctrl.play) begin
                busy     <= 1'b1;
                rom_addr <= ctrl.start;
            end
        end
    end

endmodule

// ==== hdl/pcm_mixer.sv ====
/*
  Gain mixer of the PCM player.
  Each signed 7-bit sample is scaled by its unsigned 4-bit gain, the two
  products are summed and the sum is divided by 16. The result is a
  registered signed 8-bit output one clock after its inputs change.
  The range is bounded, so no saturation is needed.
*/
`timescale 1ns/1ns

module pcm_mixer (
    input  logic               clk,
    input  logic               rst,
    input  logic signed [6:0]  snd_a,
    input  logic signed [6:0]  snd_b,
    input  pcm_pkg::mix_ctrl_t mix,
    output logic signed [7:0]  mix_out
);

    // each product lies in -960..945
    logic signed [11:0] prod_a;
    logic signed [11:0] prod_b;
    // sum lies in -1920..1890, fits 12 bits
    logic signed [11:0] sum;

    // gains are unsigned
    // a zero top bit keeps the multiply signed
    assign prod_a = snd_a * $signed({1'b0, mix.gain_a});
    assign prod_b = snd_b * $signed({1'b0, mix.gain_b});

    assign sum = prod_a + prod_b;

    // divide by 16, dropping the low nibble is an arithmetic shift
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mix_out <= '0;
        end else begin
            mix_out <= sum[11:4];
        end
    end

endmodule

// ==== hdl/pcm_top.sv ====
/*
  Top level of the two-channel PCM sample player.
  The register stage decodes host writes and makes the clock enables.
  Two identical channels fetch from their own ROM ports, and the mixer
  sums the two samples. The raw channel samples are also brought out.
*/
`timescale 1ns/1ns

module pcm_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cen,
    // host byte writes
    input  logic                       wr,
    input  logic [3:0]                 reg_addr,
    input  logic [7:0]                 data,
    // 6809-style E and Q enables
    output logic                       cen_e,
    output logic                       cen_q,
    // channel A ROM
    output logic [pcm_pkg::rom_aw-1:0] roma_addr,
    output logic                       roma_cs,
    input  logic                       roma_ok,
    input  logic [7:0]                 roma_dout,
    // channel B ROM
    output logic [pcm_pkg::rom_aw-1:0] romb_addr,
    output logic                       romb_cs,
    input  logic                       romb_ok,
    input  logic [7:0]                 romb_dout,
    // audio
    output logic signed [6:0]          snd_a,
    output logic signed [6:0]          snd_b,
    output logic signed [7:0]          mix_out
);

    pcm_pkg::chan_ctrl_t ctrl_a;
    pcm_pkg::chan_ctrl_t ctrl_b;
    pcm_pkg::mix_ctrl_t  mix;

    pcm_regs u_regs (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .wr       (wr),
        .reg_addr (reg_addr),
        .data     (data),
        .cen_e    (cen_e),
        .cen_q    (cen_q),
        .ctrl_a   (ctrl_a),
        .ctrl_b   (ctrl_b),
        .mix      (mix)
    );

    // both channels step on Q
    pcm_channel chan_a (
        .clk      (clk),
        .rst      (rst),
        .cen_q    (cen_q),
        .ctrl     (ctrl_a),
        .rom_addr (roma_addr),
        .rom_cs   (roma_cs),
        .rom_ok   (roma_ok),
        .rom_dout (roma_dout),
        .snd      (snd_a)
    );

    pcm_channel chan_b (
        .clk      (clk),
        .rst      (rst),
        .cen_q    (cen_q),
        .ctrl     (ctrl_b),
        .rom_addr (romb_addr),
        .rom_cs   (romb_cs),
        .rom_ok   (romb_ok),
        .rom_dout (romb_dout),
        .snd      (snd_b)
    );

    pcm_mixer u_mixer (
        .clk      (clk),
        .rst      (rst),
        .snd_a    (snd_a),
        .snd_b    (snd_b),
        .mix      (mix),
        .mix_out  (mix_out)
    );

endmodule

// ==== dv/pcm_checker.sv ====
/*
  Concurrent assertions on one PCM channel.
  Bound into every pcm_channel instance; watches the start pulse,
  the ROM select after reset and the ROM address between steps.
*/
`timescale 1ns/1ns

module pcm_checker (
    input logic                       clk,
    input logic                       rst,
    input logic                       play,
    input logic                       cen_q,
    input logic                       rom_cs,
    input logic [pcm_pkg::rom_aw-1:0] rom_addr
);

    // start is one clock wide
    assert property (@(posedge clk) disable iff (rst) play |=> !play)
        else $error("play pulse longer than one clock");

    // channel comes out of reset idle
    assert property (@(posedge clk) $fell(rst) |-> !rom_cs)
        else $error("rom_cs high right after reset");

    // address moves only on a Q step or a start
    assert property (@(posedge clk) disable iff (rst)
                     (rom_cs && !cen_q && !play) |=> $stable(rom_addr))
        else $error("rom_addr changed without cen_q");

endmodule

bind pcm_channel pcm_checker chk (
    .clk      (clk),
    .rst      (rst),
    .play     (ctrl.play),
    .cen_q    (cen_q),
    .rom_cs   (rom_cs),
    .rom_addr (rom_addr)
);

// ==== dv/pcm_tb.sv ====
/*
  Testbench for the two-channel PCM player.
  Serves both ROM ports from arrays, runs the commands in the stimulus
  file and checks every DUT output each clock against a cycle model
  built from the register map and channel rules.
*/
`timescale 1ns/1ns

module pcm_tb;

    // clocks per cen_q with cen at half rate
    localparam int clk_per_q = 8;

    logic                       clk;
    logic                       rst;
    logic                       cen;
    logic                       wr;
    logic [3:0]                 reg_addr;
    logic [7:0]                 data;
    logic                       cen_e;
    logic                       cen_q;
    logic [pcm_pkg::rom_aw-1:0] roma_addr;
    logic [pcm_pkg::rom_aw-1:0] romb_addr;
    logic                       roma_cs;
    logic                       romb_cs;
    logic                       roma_ok;
    logic                       romb_ok;
    logic [7:0]                 roma_dout;
    logic [7:0]                 romb_dout;
    logic signed [6:0]          snd_a;
    logic signed [6:0]          snd_b;
    logic signed [7:0]          mix_out;

    logic [7:0] rom_a [2**pcm_pkg::rom_aw];
    logic [7:0] rom_b [2**pcm_pkg::rom_aw];

    // reference model state
    logic [7:0]        regs_m [14];
    logic [1:0]        play_m;
    logic [1:0]        phase_m;
    logic              cen_e_m;
    logic              cen_q_m;
    logic [11:0]       cnt_m [2];
    logic              busy_m [2];
    logic [16:0]       addr_m [2];
    logic signed [6:0] snd_m [2];
    logic signed [7:0] mix_m;
    int                fetched [2];
    // inputs seen before the coming edge
    logic              p_cen;
    logic              p_wr;
    logic [3:0]        p_addr;
    logic [7:0]        p_data;
    logic              p_ok [2];
    bit                have_prev;

    int stall_pct;
    int errors;
    int tests;
    int cycles;
    int limit;

    pcm_top DUT (.*);

    assign roma_dout = rom_a[roma_addr];
    assign romb_dout = rom_b[romb_addr];

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic reset_model();
        for (int i = 0; i < 14; i++) begin
            regs_m[i] = '0;
        end
        for (int c = 0; c < 2; c++) begin
            cnt_m[c]  = '0;
            busy_m[c] = 1'b0;
            addr_m[c] = '0;
            snd_m[c]  = '0;
        end
        play_m    = '0;
        phase_m   = '0;
        cen_e_m   = 1'b0;
        cen_q_m   = 1'b0;
        mix_m     = '0;
        have_prev = 1'b0;
    endtask

    // one clock edge of one channel, from the values before the edge
    task automatic step_channel(input int c);
        int          base;
        logic [11:0] pre;
        logic [1:0]  sel;
        logic [16:0] start;
        logic        over;
        logic [7:0]  b;
        base  = c * 6;
        pre   = {regs_m[base+1][3:0], regs_m[base]};
        sel   = regs_m[base+1][5:4];
        start = {regs_m[base+4][0], regs_m[base+3], regs_m[base+2]};
        if (sel[0]) begin
            over = &cnt_m[c][7:0];
        end else if (sel[1]) begin
            over = &cnt_m[c][11:8];
        end else begin
            over = &cnt_m[c];
        end
        b = (c == 0) ? rom_a[addr_m[c]] : rom_b[addr_m[c]];
        if (cen_q_m && over) begin
            if (!busy_m[c]) begin
                snd_m[c] = '0;
            end else if (p_ok[c]) begin
                snd_m[c]  = 7'(int'(b[6:0]) - 64);
                addr_m[c] = addr_m[c] + 17'd1;
                fetched[c]++;
                if (b[7] && regs_m[13][c]) begin
                    addr_m[c] = start;
                end else if (b[7]) begin
                    busy_m[c] = 1'b0;
                end
            end
        end
        if (cen_q_m) begin
            cnt_m[c] = over ? pre : cnt_m[c] + 12'd1;
        end
        if (play_m[c]) begin
            busy_m[c]  = 1'b1;
            addr_m[c]  = start;
            fetched[c] = 0;
        end
    endtask

    // model update and compare, half a clock away from the edges
    always @(negedge clk) begin
        int s;
        if (rst) begin
            reset_model();
        end else begin
            if (have_prev) begin
                s = int'(snd_m[0]) * int'(regs_m[12][7:4])
                  + int'(snd_m[1]) * int'(regs_m[12][3:0]);
                mix_m = 8'(s >>> 4);
                step_channel(0);
                step_channel(1);
                if (p_wr && p_addr < 4'd14) begin
                    regs_m[p_addr] = p_data;
                end
                play_m[0] = p_wr && p_addr == 4'd5;
                play_m[1] = p_wr && p_addr == 4'd11;
                cen_q_m   = p_cen && phase_m == 2'd1;
                cen_e_m   = p_cen && phase_m == 2'd3;
                if (p_cen) begin
                    phase_m = phase_m + 2'd1;
                end
            end
            compare_value("cen_e", 32'(cen_e), 32'(cen_e_m));
            compare_value("cen_q", 32'(cen_q), 32'(cen_q_m));
            compare_value("roma_cs", 32'(roma_cs), 32'(busy_m[0]));
            compare_value("romb_cs", 32'(romb_cs), 32'(busy_m[1]));
            compare_value("roma_addr", 32'(roma_addr), 32'(addr_m[0]));
            compare_value("romb_addr", 32'(romb_addr), 32'(addr_m[1]));
            compare_value("snd_a", 32'(snd_a), 32'(snd_m[0]));
            compare_value("snd_b", 32'(snd_b), 32'(snd_m[1]));
            compare_value("mix_out", 32'(mix_out), 32'(mix_m));
            p_cen     = cen;
            p_wr      = wr;
            p_addr    = reg_addr;
            p_data    = data;
            p_ok[0]   = roma_ok;
            p_ok[1]   = romb_ok;
            have_prev = 1'b1;
        end
    end

    // cen every other clock, random ROM stalls
    always @(posedge clk) begin
        #1;
        cen     = ~cen;
        roma_ok = $urandom_range(99) >= stall_pct;
        romb_ok = $urandom_range(99) >= stall_pct;
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: no result after %0d clock cycles", limit);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic write_reg(input logic [3:0] a, input logic [7:0] d);
        @(posedge clk);
        #1;
        wr       = 1'b1;
        reg_addr = a;
        data     = d;
        @(posedge clk);
        #1;
        wr = 1'b0;
    endtask

    // wait until each channel has fetched its count since the test began
    // a start during the test clears the count again
    task automatic run_test(input int na, input int nb);
        int base_err;
        base_err = errors;
        tests++;
        fetched = '{0, 0};
        repeat (4) @(posedge clk);
        while (fetched[0] < na || fetched[1] < nb) begin
            @(posedge clk);
        end
        @(negedge clk);
        $display("test %0d: %0d/%0d samples, %0d errors", tests, na, nb, errors - base_err);
    endtask

    initial begin
        int          fd;
        int          n;
        int          total;
        string       line;
        byte         ch;
        logic [31:0] a1;
        logic [31:0] a2;
        void'($urandom(32'hb140_a554));
        rst       = 1'b1;
        cen       = 1'b0;
        wr        = 1'b0;
        reg_addr  = '0;
        data      = '0;
        roma_ok   = 1'b0;
        romb_ok   = 1'b0;
        stall_pct = 0;
        errors    = 0;
        tests     = 0;
        cycles    = 0;
        limit     = 0;
        total     = 0;
        fetched   = '{0, 0};
        for (int i = 0; i < 2**pcm_pkg::rom_aw; i++) begin
            rom_a[i] = {1'b0, 7'(i ^ (i >> 7) ^ (i >> 14))};
            rom_b[i] = {1'b0, 7'((i * 5) ^ (i >> 7) ^ (i >> 14))};
        end
        fd = $fopen("dv/pcm_stimulus.txt", "r");
        if (fd == 0) begin
            $display("stimulus file dv/pcm_stimulus.txt could not be opened");
            $display("Verification failed");
            $finish;
        end else begin
            // first pass sums the sample counts for the cycle limit
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%c %h %h", ch, a1, a2);
                if (n == 3 && ch == "t") begin
                    total += int'(a1) + int'(a2);
                end
            end
            $fclose(fd);
            limit = total * clk_per_q * 4096 * 2 + 200000;
            repeat (2) @(posedge clk);
            #1;
            rst = 1'b0;
            fd = $fopen("dv/pcm_stimulus.txt", "r");
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%c %h %h", ch, a1, a2);
                case (ch)
                    "a": rom_a[a1[16:0]] = a2[7:0];
                    "b": rom_b[a1[16:0]] = a2[7:0];
                    "w": write_reg(a1[3:0], a2[7:0]);
                    "s": stall_pct = int'(a1);
                    "c": repeat (int'(a1)) @(posedge clk);
                    "t": run_test(int'(a1), int'(a2));
                    default: ;
                endcase
            end
            $fclose(fd);
            $display("%0d tests run, %0d errors", tests, errors);
            if (errors == 0) begin
                $display("Verification passed");
            end else begin
                $display("Verification failed");
            end
            $finish;
        end
    end

endmodule

// ==== dv/pcm_stimulus.txt ====
# columns: command, then up to two hex arguments
# a/b addr byte: ROM byte; w reg data: write; s pct: stall percent; c n: wait; t na nb: test
c 28
t 0 0
a 100 50
a 101 30
a 102 7f
a 103 00
a 104 c8
b 1fff0 10
b 1fff1 60
b 1fff2 a5
w e 55
w f aa
w 0 f8
w 1 0f
w 2 00
w 3 01
w 4 00
w 5 00
t 5 0
c 200
w d 01
w 5 00
t c 0
w 6 f0
w 7 10
w 8 f0
w 9 ff
w a 01
w b 00
t 0 3
w 0 fc
w 1 2e
w 5 00
t 8 0
s 1e
w 5 00
w b 00
t a 3
s 0
w d 03
w c f8
w 5 00
w b 00
t 8 6
w c 3c
t 8 6
w c 7f
t 6 6
w d 00
c 400

// ==== verilog.f ====
hdl/pcm_pkg.sv
hdl/pcm_regs.sv
hdl/pcm_channel.sv
hdl/pcm_mixer.sv
hdl/pcm_top.sv
dv/pcm_checker.sv
dv/pcm_tb.sv

// ==== Makefile ====
# Verilator build and run of the PCM player testbench

VERILATOR ?= verilator
TOP       ?= pcm_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= verilog.f
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
